// File: test/ara_golden.txt
# Columns: instruction word, result kind (V = granted length, S = scalar), expected value
# All fields hex, text after the third column is ignored
50000000 S 0000   v0[0] after reset
50380007 S 0000   v7[7] after reset
80000005 V 5      request length 5
8000000c V 8      request 12, clamped to 8
42001234 S 0000   splat v1 = 1234
4400f00f S 0000   splat v2 = f00f
06500000 S 0000   v3 = v2 + v1
18500000 S 0000   v4 = v2 - v1
2a500000 S 0000   v5 = v2 & v1
3c500000 S 0000   v6 = v2 ^ v1
50180000 S 0243   v3[0]
50180007 S 0243   v3[7]
50200001 S dddb   v4[1]
50200006 S dddb   v4[6]
50280002 S 1004   v5[2]
50280005 S 1004   v5[5]
50300003 S e23b   v6[3]
50300004 S e23b   v6[4]
50180009 S 0243   v3 index 9 wraps to 1
80000003 V 3      request length 3
420000aa S 0000   splat v1 = 00aa on indices 0 to 2
50080000 S 00aa   v1[0]
50080001 S 00aa   v1[1]
50080002 S 00aa   v1[2]
50080003 S 1234   v1[3] tail kept
50080004 S 1234   v1[4] tail kept
50080007 S 1234   v1[7] tail kept
80000008 V 8      back to full length
6600ffff S 0000   opcode 6 aimed at v3
78500000 S 0000   opcode 7 aimed at v4
50180000 S 0243   v3[0] unchanged
50200005 S dddb   v4[5] unchanged
50100006 S f00f   v2[6] unchanged
0e480000 S 0000   v7 = v1 + v1
50380002 S 0154   v7[2]
50380005 S 2468   v7[5]
50000004 S 0000   v0[4] still zero

// File: ara.f
+incdir+src
src/ara_pkg.sv
src/ara_dispatcher.sv
src/ara_insn_queue.sv
src/ara_lane_sequencer.sv
src/ara_lane.sv
src/ara.sv
test/ara_tb.sv

// File: Makefile
# Verilator flow for the vector accelerator testbench

VERILATOR ?= verilator
TB_TOP    ?= ara_tb
RTL_TOP   ?= ara
FILELIST  ?= ara.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
# Warnings are still printed but do not stop the build
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SHELL   := /bin/bash
SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(SIM_BIN)
	set -o pipefail; ./$(SIM_BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR)

// File: test/ara_tb.sv
// Testbench for the vector accelerator
// Replays the golden request stream and checks every response in order

`timescale 1ns/1ps

`include "ara_consts.svh"

module ara_tb import ara_pkg::*; ();

  localparam int unsigned ClkHalf       = 50;
  localparam int unsigned ResetCycles   = 5;
  // Response index where the long stall starts
  localparam int unsigned StallAt       = 12;
  localparam int unsigned StallCycles   = 30;
  localparam int unsigned CyclesPerLine = 200;
  localparam string       GoldenPath    = "test/ara_golden.txt";

  logic      clk;
  logic      rst;
  ara_insn_u req;
  logic      req_valid;
  logic      req_ready;
  elem_t     resp;
  logic      resp_valid;
  logic      resp_ready;

  logic [`ARA_INSN_W-1:0] word_q [$];
  byte                    kind_q [$];
  elem_t                  expect_q [$];

  int          seed;
  int unsigned nr_lines;
  int unsigned pass_cnt;
  int unsigned fail_cnt;
  bit          loaded;
  bit          saw_backpressure;

  ara ara_inst (
    .clk_i            (clk       ),
    .rst_i            (rst       ),
    .acc_req_i        (req       ),
    .acc_req_valid_i  (req_valid ),
    .acc_req_ready_o  (req_ready ),
    .acc_resp_o       (resp      ),
    .acc_resp_valid_o (resp_valid),
    .acc_resp_ready_i (resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkHalf) clk = ~clk;
  end

  // Requests held off by exhausted credits
  always @(negedge clk) begin
    if (!rst && req_valid && !req_ready) begin
      saw_backpressure = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic record_result(input string what, input bit ok);
    if (ok) begin
      pass_cnt++;
      $display("%s: ok", what);
    end else begin
      fail_cnt++;
      $display("%s: FAILED", what);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected,
                            output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_vl(input string name, input vl_t actual, input vl_t expected,
                          output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_scalar(input string name, input elem_t actual, input elem_t expected,
                              output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_response(input int unsigned idx);
    bit    ok;
    string what;
    if (kind_q[idx] == "V") begin
      what = $sformatf("line %0d length 0x%08h", idx, word_q[idx]);
      check_vl("acc_resp_o", vl_t'(resp), vl_t'(expect_q[idx]), ok);
      if (resp[`ARA_ELEM_W-1:VlW] != '0) begin
        $display("Length response 0x%h has upper bits set", resp);
        ok = 1'b0;
      end
    end else begin
      what = $sformatf("line %0d scalar 0x%08h", idx, word_q[idx]);
      check_scalar("acc_resp_o", resp, expect_q[idx], ok);
    end
    record_result(what, ok);
  endtask

  ////////////////////////////////////////
  // Golden file and traffic
  ////////////////////////////////////////

  task automatic load_golden(output bit ok);
    int                     fd;
    int                     n_conv;
    string                  line;
    logic [`ARA_INSN_W-1:0] word;
    byte                    kind;
    elem_t                  value;
    ok = 1'b1;
    fd = $fopen(GoldenPath, "r");
    if (fd == 0) begin
      $display("Cannot open golden file %s", GoldenPath);
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") begin
        continue;
      end
      n_conv = $sscanf(line, "%h %c %h", word, kind, value);
      // Whitespace only
      if (n_conv <= 0) begin
        continue;
      end
      if (n_conv != 3 || (kind != "V" && kind != "S")) begin
        $display("Malformed golden line: %s", line);
        ok = 1'b0;
        continue;
      end
      word_q.push_back(word);
      kind_q.push_back(kind);
      expect_q.push_back(value);
    end
    $fclose(fd);
    if (word_q.size() == 0) begin
      $display("Golden file holds no requests");
      ok = 1'b0;
    end
  endtask

  task automatic drive_requests();
    @(posedge clk);
    for (int unsigned i = 0; i < nr_lines; i++) begin
      req       <= word_q[i];
      req_valid <= 1'b1;
      // Transfer completes on the edge after ready is seen
      do begin
        @(negedge clk);
      end while (!req_ready);
      @(posedge clk);
    end
    req_valid <= 1'b0;
  endtask

  task automatic collect_responses();
    int unsigned n;
    int unsigned hold;
    bit          stalled;
    bit          extra;
    n       = 0;
    hold    = 0;
    stalled = 1'b0;
    extra   = 1'b0;
    while (n < nr_lines) begin
      @(posedge clk);
      // One long stall lets the queue and credits run dry
      if (n == StallAt && !stalled) begin
        stalled = 1'b1;
        hold    = StallCycles;
      end
      if (hold != 0) begin
        hold--;
        resp_ready <= 1'b0;
      end else begin
        resp_ready <= ($random(seed) & 3) != 0;
      end
      @(negedge clk);
      if (resp_valid && resp_ready) begin
        check_response(n);
        n++;
      end
    end
    // Nothing may follow the last expected response
    @(posedge clk);
    resp_ready <= 1'b1;
    repeat (10) begin
      @(negedge clk);
      if (resp_valid) begin
        extra = 1'b1;
      end
    end
    if (extra) begin
      $display("Response arrived beyond the last golden line");
    end
    record_result("no extra response", !extra);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin : main
    bit load_ok;
    bit ready_ok;
    bit idle_ok;
    seed       = 32'h6126468b;
    pass_cnt   = 0;
    fail_cnt   = 0;
    rst        = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    load_golden(load_ok);
    nr_lines = word_q.size();
    loaded   = 1'b1;
    if (!load_ok) begin
      fail_cnt++;
    end
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag("acc_req_ready_o", req_ready, 1'b1, ready_ok);
    check_flag("acc_resp_valid_o", resp_valid, 1'b0, idle_ok);
    record_result("reset state", ready_ok && idle_ok);
    if (load_ok) begin
      fork
        drive_requests();
        collect_responses();
      join
      if (!saw_backpressure) begin
        $display("Request ready never fell while responses were withheld");
      end
      record_result("back-pressure", saw_backpressure);
    end
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    repeat (ResetCycles + (nr_lines + 2) * CyclesPerLine) @(posedge clk);
    $display("Timeout with %0d golden lines, responses stopped arriving", nr_lines);
    $display("sim failed");
    $finish;
  end

endmodule

// File: src/ara.sv
// Vector accelerator top level
// Dispatcher, instruction queue, lane sequencer and parallel lanes

`timescale 1ns/1ps

`include "ara_consts.svh"

module ara import ara_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Core request port
  input  ara_insn_u acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  // Core response port
  output elem_t     acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  localparam int unsigned LaneIdW = $clog2(`ARA_NR_LANES);

  // Dispatcher to queue
  logic     issue_valid;
  ara_req_t issue_req;
  logic     credit_return;
  // Queue to sequencer
  logic     head_valid;
  ara_req_t head_req;
  logic     pop;
  // Sequencer and lanes
  logic     exec_valid;
  ara_req_t exec_req;
  elem_t [`ARA_NR_LANES-1:0][`ARA_ELEMS_PER_LANE-1:0] lane_read;

  ////////////////////////////////////////
  // Front end
  ////////////////////////////////////////

  ara_dispatcher i_dispatcher (
    .clk_i           (clk_i          ),
    .rst_i           (rst_i          ),
    .acc_req_i       (acc_req_i      ),
    .acc_req_valid_i (acc_req_valid_i),
    .acc_req_ready_o (acc_req_ready_o),
    .credit_return_i (credit_return  ),
    .issue_valid_o   (issue_valid    ),
    .issue_req_o     (issue_req      )
  );

  ara_insn_queue i_insn_queue (
    .clk_i           (clk_i        ),
    .rst_i           (rst_i        ),
    .issue_valid_i   (issue_valid  ),
    .issue_req_i     (issue_req    ),
    .pop_i           (pop          ),
    .head_valid_o    (head_valid   ),
    .head_req_o      (head_req     ),
    .credit_return_o (credit_return)
  );

  ara_lane_sequencer i_lane_sequencer (
    .clk_i            (clk_i           ),
    .rst_i            (rst_i           ),
    .head_valid_i     (head_valid      ),
    .head_req_i       (head_req        ),
    .lane_read_i      (lane_read       ),
    .acc_resp_ready_i (acc_resp_ready_i),
    .pop_o            (pop             ),
    .exec_valid_o     (exec_valid      ),
    .exec_req_o       (exec_req        ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o)
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  for (genvar lane = 0; lane < `ARA_NR_LANES; lane++) begin : gen_lanes
    ara_lane i_lane (
      .clk_i        (clk_i            ),
      .rst_i        (rst_i            ),
      .lane_id_i    (LaneIdW'(lane)   ),
      .exec_valid_i (exec_valid       ),
      .exec_req_i   (exec_req         ),
      .read_elem_o  (lane_read[lane]  )
    );
  end : gen_lanes

endmodule

// File: src/ara_lane.sv
// Vector lane
// One slice of the register file plus its element ALU

`timescale 1ns/1ps

`include "ara_consts.svh"

module ara_lane import ara_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [$clog2(`ARA_NR_LANES)-1:0]      lane_id_i,
  input  logic                                  exec_valid_i,
  input  ara_req_t                              exec_req_i,
  output elem_t [`ARA_ELEMS_PER_LANE-1:0]       read_elem_o
);

  elem_t [`ARA_ELEMS_PER_LANE-1:0] vrf_q [`ARA_NR_VREGS];
  elem_t [`ARA_ELEMS_PER_LANE-1:0] alu_res;
  logic  [`ARA_ELEMS_PER_LANE-1:0] elem_we;
  logic                            writes_vd;

  // Source operand for scalar moves
  assign read_elem_o = vrf_q[exec_req_i.vs2];

  ////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////

  always_comb begin
    writes_vd = 1'b0;
    if (exec_valid_i && !exec_req_i.is_cfg) begin
      case (exec_req_i.op)
        OP_VADD, OP_VSUB, OP_VAND, OP_VXOR, OP_VSPLAT: writes_vd = 1'b1;
        default: writes_vd = 1'b0;
      endcase
    end
  end

  always_comb begin
    for (int unsigned e = 0; e < `ARA_ELEMS_PER_LANE; e++) begin
      case (exec_req_i.op)
        OP_VADD:   alu_res[e] = vrf_q[exec_req_i.vs2][e] + vrf_q[exec_req_i.vs1][e];
        // vd = vs2 - vs1
        OP_VSUB:   alu_res[e] = vrf_q[exec_req_i.vs2][e] - vrf_q[exec_req_i.vs1][e];
        OP_VAND:   alu_res[e] = vrf_q[exec_req_i.vs2][e] & vrf_q[exec_req_i.vs1][e];
        OP_VXOR:   alu_res[e] = vrf_q[exec_req_i.vs2][e] ^ vrf_q[exec_req_i.vs1][e];
        OP_VSPLAT: alu_res[e] = exec_req_i.imm;
        default:   alu_res[e] = '0;
      endcase
      // Tail elements past the stamped length are left alone
      elem_we[e] = writes_vd &&
                   ((e * `ARA_NR_LANES + int'(lane_id_i)) < int'(exec_req_i.vl));
    end
  end

  ////////////////////////////////////////
  // Register file slice
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int unsigned r = 0; r < `ARA_NR_VREGS; r++) begin
        vrf_q[r] <= '0;
      end
    end else begin
      for (int unsigned e = 0; e < `ARA_ELEMS_PER_LANE; e++) begin
        if (elem_we[e]) begin
          vrf_q[exec_req_i.vd][e] <= alu_res[e];
        end
      end
    end
  end

endmodule

// File: src/ara_lane_sequencer.sv
// Lane sequencer
// Pops queue entries, broadcasts them to all lanes and returns one
// registered response per instruction

`timescale 1ns/1ps

`include "ara_consts.svh"

module ara_lane_sequencer import ara_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     head_valid_i,
  input  ara_req_t head_req_i,
  input  elem_t [`ARA_NR_LANES-1:0][`ARA_ELEMS_PER_LANE-1:0] lane_read_i,
  input  logic     acc_resp_ready_i,
  output logic     pop_o,
  output logic     exec_valid_o,
  output ara_req_t exec_req_o,
  output elem_t    acc_resp_o,
  output logic     acc_resp_valid_o
);

  localparam int unsigned LaneSelW = $clog2(`ARA_NR_LANES);
  localparam int unsigned ElemIdxW = $clog2(`ARA_MAX_VL);

  logic                take;
  logic [ElemIdxW-1:0] elem_idx;
  elem_t               mvxs_elem;
  elem_t               resp_d;
  elem_t               resp_q;
  logic                resp_valid_q;

  ////////////////////////////////////////
  // Issue to the lanes
  ////////////////////////////////////////

  // Response slot must be free or draining this cycle
  assign take         = head_valid_i & (~resp_valid_q | acc_resp_ready_i);
  assign pop_o        = take;
  assign exec_valid_o = take;
  assign exec_req_o   = head_req_i;

  // Index wraps at the full register length
  assign elem_idx = head_req_i.imm[ElemIdxW-1:0];

  // Element i lives in lane i mod lanes, local slot i / lanes
  assign mvxs_elem = lane_read_i[elem_idx[LaneSelW-1:0]][elem_idx[ElemIdxW-1:LaneSelW]];

  always_comb begin
    resp_d = '0;
    if (head_req_i.is_cfg) begin
      resp_d = elem_t'(head_req_i.vl);
    end else if (head_req_i.op == OP_VMVXS) begin
      resp_d = mvxs_elem;
    end
  end

  ////////////////////////////////////////
  // Response register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (take) begin
      resp_valid_q <= 1'b1;
    end else if (acc_resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      resp_q <= resp_d;
    end
  end

  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = resp_valid_q;

  // A stalled response holds until the core takes it
  a_resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_q && !acc_resp_ready_i |=> resp_valid_q && $stable(resp_q))
    else $error("response changed while stalled");

endmodule

// File: src/ara_insn_queue.sv
// Instruction queue
// Circular buffer of issued entries, one credit back per pop

`timescale 1ns/1ps

`include "ara_consts.svh"

module ara_insn_queue import ara_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     issue_valid_i,
  input  ara_req_t issue_req_i,
  input  logic     pop_i,
  output logic     head_valid_o,
  output ara_req_t head_req_o,
  output logic     credit_return_o
);

  localparam int unsigned PtrW = $clog2(`ARA_QUEUE_DEPTH);
  localparam int unsigned CntW = $clog2(`ARA_QUEUE_DEPTH + 1);

  ara_req_t        mem_q [`ARA_QUEUE_DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_pop;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(`ARA_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_valid_o    = (count_q != '0);
  assign head_req_o      = mem_q[rd_ptr_q];
  assign do_pop          = pop_i & head_valid_o;
  // Slot freed this cycle goes straight back to the dispatcher
  assign credit_return_o = do_pop;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (issue_valid_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CntW'(issue_valid_i) - CntW'(do_pop);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      mem_q[wr_ptr_q] <= issue_req_i;
    end
  end

  // Dispatcher credits must keep pushes off a full queue
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_valid_i |-> count_q < CntW'(`ARA_QUEUE_DEPTH))
    else $error("push into full queue, credit violation");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> head_valid_o)
    else $error("pop from empty queue");

endmodule

// File: src/ara_dispatcher.sv
// Request dispatcher
// Decodes accelerator requests, keeps the vector length and spends
// queue credits to issue entries

`timescale 1ns/1ps

`include "ara_consts.svh"

module ara_dispatcher import ara_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  ara_insn_u acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  input  logic      credit_return_i,
  output logic      issue_valid_o,
  output ara_req_t  issue_req_o
);

  localparam int unsigned CreditW = $clog2(`ARA_QUEUE_DEPTH + 1);

  logic [CreditW-1:0] credits_q;
  vl_t                vl_q;
  vl_t                vl_granted;
  logic               accept;
  ara_req_t           req_d;

  // Accept only while the queue has room reserved for us
  assign acc_req_ready_o = ~rst_i & (credits_q != '0);
  assign accept          = acc_req_valid_i & acc_req_ready_o;

  // Requested length, clamped to what the lanes hold
  always_comb begin
    if (acc_req_i.cfg.vl > vl_t'(`ARA_MAX_VL)) begin
      vl_granted = vl_t'(`ARA_MAX_VL);
    end else begin
      vl_granted = acc_req_i.cfg.vl;
    end
  end

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  always_comb begin
    req_d = '0;
    if (acc_req_i.cfg.kind) begin
      req_d.is_cfg = 1'b1;
      req_d.vl     = vl_granted;
    end else begin
      req_d.op  = acc_req_i.arith.op;
      req_d.vd  = acc_req_i.arith.vd;
      req_d.vs1 = acc_req_i.arith.vs1;
      req_d.vs2 = acc_req_i.arith.vs2;
      req_d.imm = acc_req_i.arith.imm;
      // Stamp with the length in force at acceptance
      req_d.vl  = vl_q;
    end
  end

  ////////////////////////////////////////
  // Credits, length and issue
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits_q     <= CreditW'(`ARA_QUEUE_DEPTH);
      vl_q          <= vl_t'(`ARA_MAX_VL);
      issue_valid_o <= 1'b0;
    end else begin
      credits_q     <= credits_q - CreditW'(accept) + CreditW'(credit_return_i);
      issue_valid_o <= accept;
      if (accept && acc_req_i.cfg.kind) begin
        vl_q <= vl_granted;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_req_o <= req_d;
    end
  end

  // Queue returns at most what was spent
  a_credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    credits_q <= CreditW'(`ARA_QUEUE_DEPTH))
    else $error("credit counter above queue depth");

endmodule

// File: src/ara_pkg.sv
// Shared types of the vector accelerator
// Element, length, opcode, instruction word and queue entry

`include "ara_consts.svh"

package ara_pkg;

  // Vector length field width, enough to hold 0 to ARA_MAX_VL
  localparam int unsigned VlW = $clog2(`ARA_MAX_VL + 1);

  typedef logic [`ARA_ELEM_W-1:0] elem_t;
  typedef logic [VlW-1:0] vl_t;
  typedef logic [$clog2(`ARA_NR_VREGS)-1:0] vreg_idx_t;

  // Codes 6 and 7 are unassigned and behave as no-operations
  typedef enum logic [2:0] {
    OP_VADD   = 3'd0,
    OP_VSUB   = 3'd1,
    OP_VAND   = 3'd2,
    OP_VXOR   = 3'd3,
    OP_VSPLAT = 3'd4,
    OP_VMVXS  = 3'd5
  } ara_op_e;

  // Instruction word, kind bit on top picks the view
  typedef union packed {
    struct packed {
      logic      kind;
      ara_op_e   op;
      vreg_idx_t vd;
      vreg_idx_t vs1;
      vreg_idx_t vs2;
      logic [2:0] rsvd;
      elem_t     imm;
    } arith;
    struct packed {
      logic                       kind;
      logic [`ARA_INSN_W-VlW-2:0] unused;
      vl_t                        vl;
    } cfg;
  } ara_insn_u;

  // Queue entry as issued by the dispatcher
  // Config entries hold the granted length in vl
  typedef struct packed {
    ara_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     imm;
    vl_t       vl;
    logic      is_cfg;
  } ara_req_t;

endpackage

// File: src/ara_consts.svh
// Design-wide sizes of the vector accelerator
// Lane count, register file shape, element and instruction widths

`ifndef ARA_CONSTS_SVH
`define ARA_CONSTS_SVH

////////////////////////////////////////
// Lanes and register file
////////////////////////////////////////

// Parallel lanes, each holding a slice of every vector register
`define ARA_NR_LANES 4
// Elements of one register stored in each lane
`define ARA_ELEMS_PER_LANE 2
// Longest vector the machine can hold
`define ARA_MAX_VL (`ARA_NR_LANES * `ARA_ELEMS_PER_LANE)
`define ARA_NR_VREGS 8

////////////////////////////////////////
// Widths and buffering
////////////////////////////////////////

`define ARA_ELEM_W 16
`define ARA_INSN_W 32
// Instruction queue entries, equal to the dispatcher credit count
`define ARA_QUEUE_DEPTH 4

`endif
